// File: pmt_regs_config.svh
`ifndef PMT_REGS_CONFIG_SVH
`define PMT_REGS_CONFIG_SVH

// bus widths
`define PMT_DATA_W      32
`define PMT_ADDR_W      16

// word index inside a page, taken from address bits 8:2
`define PMT_IDX_W       7

// page numbers, address bits 15:9
`define PMT_PAGE_REGS   7'd0
`define PMT_PAGE_INFO   7'd8

// returned for unmapped or misaligned reads
`define PMT_DEAD_WORD   32'h00DEAD00

// five words of four characters, first characters in the top word
`define PMT_VERSION     "PCG1_PMTM_v1.0      "

`endif

// File: pmt_regs_pkg.sv
`include "pmt_regs_config.svh"

package pmt_regs_pkg;

    ////////////////////////////////////////
    // host bus
    ////////////////////////////////////////
    typedef logic [`PMT_DATA_W-1:0] reg_word_t;
    typedef logic [`PMT_ADDR_W-1:0] reg_addr_t;

    // address split into page and word index
    typedef logic [`PMT_IDX_W-1:0] reg_idx_t;
    typedef logic [`PMT_ADDR_W-`PMT_IDX_W-3:0] reg_page_t;

    ////////////////////////////////////////
    // register fields
    ////////////////////////////////////////
    // thresholds and adc offset
    typedef logic [15:0] thre_t;

    // pmt high voltage dac code
    typedef logic [11:0] dac_code_t;

    // event counters from the datapath
    typedef logic [`PMT_DATA_W-1:0] cnt_t;

endpackage

// File: reg_bank_if.sv
`timescale 1ns/1ps

interface reg_bank_if;
    import pmt_regs_pkg::*;

    // write side, one page
    logic      wr_en;
    reg_idx_t  idx;
    reg_word_t wr_data;

    // read side, combinational from the bank
    reg_word_t rd_data;
    logic      hit;

    modport ctrl (output wr_en, idx, wr_data, input rd_data, hit);

    modport bank (input wr_en, idx, wr_data, output rd_data, hit);

    // info page has no writable state
    modport rd_only (input idx, output rd_data, hit);

endinterface

// File: pmt_reg_ctrl.sv
`timescale 1ns/1ps
`include "pmt_regs_config.svh"

module pmt_reg_ctrl (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  wr_en_i,
    input  logic                  rd_en_i,
    input  pmt_regs_pkg::reg_addr_t addr_i,
    input  pmt_regs_pkg::reg_word_t wr_data_i,
    output logic                  rd_vld_o,
    output pmt_regs_pkg::reg_word_t rd_data_o,
    reg_bank_if.ctrl              analog_bus,
    reg_bank_if.ctrl              acc_bus,
    reg_bank_if.ctrl              info_bus
);
    import pmt_regs_pkg::*;

    reg_page_t page;
    reg_idx_t  idx;
    logic      aligned;
    logic      in_regs;
    logic      in_info;
    reg_word_t rd_word;
    reg_word_t rd_data_q;
    logic      rd_vld_q;

    ////////////////////////////////////////
    // address decode
    ////////////////////////////////////////
    assign page    = addr_i[`PMT_ADDR_W-1:`PMT_IDX_W+2];
    assign idx     = addr_i[`PMT_IDX_W+1:2];
    assign aligned = (addr_i[1:0] == 2'b00);
    assign in_regs = aligned && (page == `PMT_PAGE_REGS);
    assign in_info = aligned && (page == `PMT_PAGE_INFO);

    // both page 0 banks see the same strobe, each keeps its own indices
    assign analog_bus.wr_en   = wr_en_i && in_regs;
    assign analog_bus.idx     = idx;
    assign analog_bus.wr_data = wr_data_i;
    assign acc_bus.wr_en      = wr_en_i && in_regs;
    assign acc_bus.idx        = idx;
    assign acc_bus.wr_data    = wr_data_i;

    // read only page
    assign info_bus.wr_en   = 1'b0;
    assign info_bus.idx     = idx;
    assign info_bus.wr_data = wr_data_i;

    ////////////////////////////////////////
    // read path
    ////////////////////////////////////////
    always_comb begin
        rd_word = `PMT_DEAD_WORD;
        if (in_regs && analog_bus.hit) begin
            rd_word = analog_bus.rd_data;
        end else if (in_regs && acc_bus.hit) begin
            rd_word = acc_bus.rd_data;
        end else if (in_info && info_bus.hit) begin
            rd_word = info_bus.rd_data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_vld_q <= 1'b0;
        end else begin
            rd_vld_q <= rd_en_i;
        end
    end

    // data holds until the next read
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data_q <= rd_word;
        end
    end

    assign rd_vld_o  = rd_vld_q;
    assign rd_data_o = rd_data_q;

endmodule

// File: pmt_analog_regs.sv
`timescale 1ns/1ps

module pmt_analog_regs (
    input  logic                    clk_i,
    input  logic                    reset_i,
    reg_bank_if.bank                bus,
    output pmt_regs_pkg::thre_t     adc_offset_o,
    output logic                    adc_offset_en_o,
    output pmt_regs_pkg::dac_code_t dac_data_o,
    output logic                    dac_config_en_o,
    output logic                    bst_vcc_en_o,
    output logic                    pmt_test_en_o
);
    import pmt_regs_pkg::*;

    // word indices in page 0
    localparam reg_idx_t IDX_ADC_OFFSET = 7'd6;
    localparam reg_idx_t IDX_DAC_DATA   = 7'd7;
    localparam reg_idx_t IDX_BST_VCC    = 7'd8;
    localparam reg_idx_t IDX_PMT_TEST   = 7'd9;

    thre_t     adc_offset_q;
    dac_code_t dac_data_q;
    logic      bst_vcc_en_q;
    logic      pmt_test_en_q;
    logic      adc_offset_en_q;
    logic      dac_config_en_q;

    ////////////////////////////////////////
    // write side
    ////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            adc_offset_q    <= '0;
            dac_data_q      <= '0;
            bst_vcc_en_q    <= 1'b1;
            pmt_test_en_q   <= 1'b0;
            adc_offset_en_q <= 1'b0;
            dac_config_en_q <= 1'b0;
        end else begin
            // update pulses last one cycle
            adc_offset_en_q <= 1'b0;
            dac_config_en_q <= 1'b0;
            if (bus.wr_en) begin
                case (bus.idx)
                    IDX_ADC_OFFSET: begin
                        adc_offset_q    <= bus.wr_data[15:0];
                        adc_offset_en_q <= 1'b1;
                    end
                    IDX_DAC_DATA: begin
                        dac_data_q      <= bus.wr_data[11:0];
                        dac_config_en_q <= 1'b1;
                    end
                    IDX_BST_VCC:  bst_vcc_en_q  <= bus.wr_data[0];
                    IDX_PMT_TEST: pmt_test_en_q <= bus.wr_data[0];
                    default: ;
                endcase
            end
        end
    end

    // readback, zero extended
    always_comb begin
        bus.hit     = 1'b1;
        bus.rd_data = '0;
        case (bus.idx)
            IDX_ADC_OFFSET: bus.rd_data = reg_word_t'(adc_offset_q);
            IDX_DAC_DATA:   bus.rd_data = reg_word_t'(dac_data_q);
            IDX_BST_VCC:    bus.rd_data = reg_word_t'(bst_vcc_en_q);
            IDX_PMT_TEST:   bus.rd_data = reg_word_t'(pmt_test_en_q);
            default:        bus.hit     = 1'b0;
        endcase
    end

    assign adc_offset_o    = adc_offset_q;
    assign adc_offset_en_o = adc_offset_en_q;
    assign dac_data_o      = dac_data_q;
    assign dac_config_en_o = dac_config_en_q;
    assign bst_vcc_en_o    = bst_vcc_en_q;
    assign pmt_test_en_o   = pmt_test_en_q;

endmodule

// File: pmt_acc_regs.sv
`timescale 1ns/1ps

module pmt_acc_regs (
    input  logic                clk_i,
    input  logic                reset_i,
    reg_bank_if.bank            bus,
    output logic                acc_defect_en_o,
    output pmt_regs_pkg::thre_t pre_acc_curr_thre_o,
    output pmt_regs_pkg::thre_t actu_acc_curr_thre_o,
    output pmt_regs_pkg::thre_t actu_acc_cache_thre_o,
    output logic [2:0]          particle_acc_bypass_o,
    output logic                first_track_ctrl_o
);
    import pmt_regs_pkg::*;

    // word indices in page 0
    localparam reg_idx_t IDX_DEFECT_EN  = 7'd5;
    localparam reg_idx_t IDX_PRE_CURR   = 7'd14;
    localparam reg_idx_t IDX_ACTU_CURR  = 7'd15;
    localparam reg_idx_t IDX_ACTU_CACHE = 7'd16;
    localparam reg_idx_t IDX_BYPASS     = 7'd17;
    localparam reg_idx_t IDX_FIRST_TRK  = 7'd18;

    logic       defect_en_q;
    thre_t      pre_curr_q;
    thre_t      actu_curr_q;
    thre_t      actu_cache_q;
    logic [2:0] bypass_q;
    logic       first_trk_q;

    ////////////////////////////////////////
    // write side
    ////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            defect_en_q  <= 1'b0;
            pre_curr_q   <= '0;
            actu_curr_q  <= '0;
            actu_cache_q <= '0;
            bypass_q     <= '0;
            first_trk_q  <= 1'b1;
        end else if (bus.wr_en) begin
            // upper bits dropped
            case (bus.idx)
                IDX_DEFECT_EN:  defect_en_q  <= bus.wr_data[0];
                IDX_PRE_CURR:   pre_curr_q   <= bus.wr_data[15:0];
                IDX_ACTU_CURR:  actu_curr_q  <= bus.wr_data[15:0];
                IDX_ACTU_CACHE: actu_cache_q <= bus.wr_data[15:0];
                IDX_BYPASS:     bypass_q     <= bus.wr_data[2:0];
                IDX_FIRST_TRK:  first_trk_q  <= bus.wr_data[0];
                default: ;
            endcase
        end
    end

    always_comb begin
        bus.hit     = 1'b1;
        bus.rd_data = '0;
        case (bus.idx)
            IDX_DEFECT_EN:  bus.rd_data = reg_word_t'(defect_en_q);
            IDX_PRE_CURR:   bus.rd_data = reg_word_t'(pre_curr_q);
            IDX_ACTU_CURR:  bus.rd_data = reg_word_t'(actu_curr_q);
            IDX_ACTU_CACHE: bus.rd_data = reg_word_t'(actu_cache_q);
            IDX_BYPASS:     bus.rd_data = reg_word_t'(bypass_q);
            IDX_FIRST_TRK:  bus.rd_data = reg_word_t'(first_trk_q);
            default:        bus.hit     = 1'b0;
        endcase
    end

    assign acc_defect_en_o       = defect_en_q;
    assign pre_acc_curr_thre_o   = pre_curr_q;
    assign actu_acc_curr_thre_o  = actu_curr_q;
    assign actu_acc_cache_thre_o = actu_cache_q;
    assign particle_acc_bypass_o = bypass_q;
    assign first_track_ctrl_o    = first_trk_q;

endmodule

// File: pmt_info_regs.sv
`timescale 1ns/1ps
`include "pmt_regs_config.svh"

module pmt_info_regs (
    reg_bank_if.rd_only         bus,
    input pmt_regs_pkg::cnt_t   dbg_acc_flag_cnt_i,
    input pmt_regs_pkg::cnt_t   pre_widen_result_cnt_i,
    input pmt_regs_pkg::cnt_t   curr_widen_result_cnt_i,
    input pmt_regs_pkg::cnt_t   cache_widen_result_cnt_i
);

    localparam int W = `PMT_DATA_W;
    localparam logic [5*W-1:0] VERSION = `PMT_VERSION;

    always_comb begin
        bus.hit     = 1'b1;
        bus.rd_data = '0;
        case (bus.idx)
            // version string, 0x1000 to 0x1010
            7'd0:  bus.rd_data = VERSION[4*W +: W];
            7'd1:  bus.rd_data = VERSION[3*W +: W];
            7'd2:  bus.rd_data = VERSION[2*W +: W];
            7'd3:  bus.rd_data = VERSION[1*W +: W];
            7'd4:  bus.rd_data = VERSION[0*W +: W];
            // event counters, 0x1100 to 0x110c
            7'd64: bus.rd_data = dbg_acc_flag_cnt_i;
            7'd65: bus.rd_data = pre_widen_result_cnt_i;
            7'd66: bus.rd_data = curr_widen_result_cnt_i;
            7'd67: bus.rd_data = cache_widen_result_cnt_i;
            default: bus.hit   = 1'b0;
        endcase
    end

endmodule

// File: pmt_reg_map.sv
`timescale 1ns/1ps

module pmt_reg_map (
    input  logic                    clk_i,
    input  logic                    reset_i,

    // host strobes
    input  logic                    slave_wr_en_i,
    input  logic                    slave_rd_en_i,
    input  pmt_regs_pkg::reg_addr_t slave_addr_i,
    input  pmt_regs_pkg::reg_word_t slave_wr_data_i,
    output logic                    slave_rd_vld_o,
    output pmt_regs_pkg::reg_word_t slave_rd_data_o,

    // datapath counters
    input  pmt_regs_pkg::cnt_t      dbg_acc_flag_cnt_i,
    input  pmt_regs_pkg::cnt_t      pre_widen_result_cnt_i,
    input  pmt_regs_pkg::cnt_t      curr_widen_result_cnt_i,
    input  pmt_regs_pkg::cnt_t      cache_widen_result_cnt_i,

    // analog front end
    output pmt_regs_pkg::thre_t     adc_offset_o,
    output logic                    adc_offset_en_o,
    output pmt_regs_pkg::dac_code_t dac_data_o,
    output logic                    dac_config_en_o,
    output logic                    bst_vcc_en_o,
    output logic                    pmt_test_en_o,

    // particle accumulation
    output logic                    acc_defect_en_o,
    output pmt_regs_pkg::thre_t     pre_acc_curr_thre_o,
    output pmt_regs_pkg::thre_t     actu_acc_curr_thre_o,
    output pmt_regs_pkg::thre_t     actu_acc_cache_thre_o,
    output logic [2:0]              particle_acc_bypass_o,
    output logic                    first_track_ctrl_o
);

    ////////////////////////////////////////
    // bank buses, two on page 0
    ////////////////////////////////////////
    reg_bank_if analog_bus ();
    reg_bank_if acc_bus ();
    reg_bank_if info_bus ();

    pmt_reg_ctrl u_ctrl (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .wr_en_i    (slave_wr_en_i),
        .rd_en_i    (slave_rd_en_i),
        .addr_i     (slave_addr_i),
        .wr_data_i  (slave_wr_data_i),
        .rd_vld_o   (slave_rd_vld_o),
        .rd_data_o  (slave_rd_data_o),
        .analog_bus (analog_bus),
        .acc_bus    (acc_bus),
        .info_bus   (info_bus)
    );

    pmt_analog_regs u_analog (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .bus             (analog_bus),
        .adc_offset_o    (adc_offset_o),
        .adc_offset_en_o (adc_offset_en_o),
        .dac_data_o      (dac_data_o),
        .dac_config_en_o (dac_config_en_o),
        .bst_vcc_en_o    (bst_vcc_en_o),
        .pmt_test_en_o   (pmt_test_en_o)
    );

    pmt_acc_regs u_acc (
        .clk_i                 (clk_i),
        .reset_i               (reset_i),
        .bus                   (acc_bus),
        .acc_defect_en_o       (acc_defect_en_o),
        .pre_acc_curr_thre_o   (pre_acc_curr_thre_o),
        .actu_acc_curr_thre_o  (actu_acc_curr_thre_o),
        .actu_acc_cache_thre_o (actu_acc_cache_thre_o),
        .particle_acc_bypass_o (particle_acc_bypass_o),
        .first_track_ctrl_o    (first_track_ctrl_o)
    );

    // read only, no clock
    pmt_info_regs u_info (
        .bus                      (info_bus),
        .dbg_acc_flag_cnt_i       (dbg_acc_flag_cnt_i),
        .pre_widen_result_cnt_i   (pre_widen_result_cnt_i),
        .curr_widen_result_cnt_i  (curr_widen_result_cnt_i),
        .cache_widen_result_cnt_i (cache_widen_result_cnt_i)
    );

endmodule

// File: pmt_reg_map_props.sv
`timescale 1ns/1ps

module pmt_reg_map_props (
    input logic                    clk_i,
    input logic                    reset_i,
    input logic                    slave_wr_en_i,
    input logic                    slave_rd_en_i,
    input pmt_regs_pkg::reg_addr_t slave_addr_i,
    input logic                    slave_rd_vld_o,
    input logic                    adc_offset_en_o,
    input logic                    dac_config_en_o
);

    // valid follows the read enable by one cycle
    rd_vld_follows: assert property (@(posedge clk_i)
        !reset_i |=> (slave_rd_vld_o == $past(slave_rd_en_i)))
        else $error("read valid does not follow the read enable");

    // update strobes only after a write to their own address
    adc_strobe: assert property (@(posedge clk_i)
        !reset_i |=> (adc_offset_en_o == $past(slave_wr_en_i && slave_addr_i == 16'h0018)))
        else $error("adc offset strobe does not match a write to 0x0018");

    dac_strobe: assert property (@(posedge clk_i)
        !reset_i |=> (dac_config_en_o == $past(slave_wr_en_i && slave_addr_i == 16'h001C)))
        else $error("dac strobe does not match a write to 0x001c");

    reset_quiet: assert property (@(posedge clk_i)
        reset_i |=> (!slave_rd_vld_o && !adc_offset_en_o && !dac_config_en_o))
        else $error("strobe or valid high after reset");

endmodule

bind pmt_reg_map pmt_reg_map_props u_props (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .slave_wr_en_i   (slave_wr_en_i),
    .slave_rd_en_i   (slave_rd_en_i),
    .slave_addr_i    (slave_addr_i),
    .slave_rd_vld_o  (slave_rd_vld_o),
    .adc_offset_en_o (adc_offset_en_o),
    .dac_config_en_o (dac_config_en_o)
);

// File: tb_pmt_reg_map.sv
`timescale 1ns/1ps

module tb_pmt_reg_map;
    import pmt_regs_pkg::*;

    localparam int NUM_REGS       = 10;
    localparam int TIMEOUT_CYCLES = 2000;

    // writable registers: address, width mask, reset value
    localparam logic [15:0] REG_ADDR [NUM_REGS] = '{16'h0014, 16'h0018, 16'h001C, 16'h0020,
        16'h0024, 16'h0038, 16'h003C, 16'h0040, 16'h0044, 16'h0048};
    localparam reg_word_t REG_MASK [NUM_REGS] = '{32'h1, 32'hFFFF, 32'hFFF, 32'h1, 32'h1,
        32'hFFFF, 32'hFFFF, 32'hFFFF, 32'h7, 32'h1};
    localparam reg_word_t REG_DEF [NUM_REGS] = '{0, 0, 0, 1, 0, 0, 0, 0, 0, 1};

    // "PCG1_PMTM_v1.0" and six spaces, ascii
    localparam reg_word_t VERSION_WORDS [5] = '{32'h50434731, 32'h5F504D54, 32'h4D5F7631,
        32'h2E302020, 32'h20202020};

    logic       clk_i;
    logic       reset_i;
    logic       slave_wr_en_i;
    logic       slave_rd_en_i;
    reg_addr_t  slave_addr_i;
    reg_word_t  slave_wr_data_i;
    logic       slave_rd_vld_o;
    reg_word_t  slave_rd_data_o;
    cnt_t       dbg_acc_flag_cnt_i;
    cnt_t       pre_widen_result_cnt_i;
    cnt_t       curr_widen_result_cnt_i;
    cnt_t       cache_widen_result_cnt_i;
    thre_t      adc_offset_o;
    logic       adc_offset_en_o;
    dac_code_t  dac_data_o;
    logic       dac_config_en_o;
    logic       bst_vcc_en_o;
    logic       pmt_test_en_o;
    logic       acc_defect_en_o;
    thre_t      pre_acc_curr_thre_o;
    thre_t      actu_acc_curr_thre_o;
    thre_t      actu_acc_cache_thre_o;
    logic [2:0] particle_acc_bypass_o;
    logic       first_track_ctrl_o;

    integer    seed;
    int        cycle_cnt;
    reg_word_t shadow [NUM_REGS];
    cnt_t      cnt_vals [4];

    pmt_reg_map u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run went past %0d cycles", TIMEOUT_CYCLES);
            stop_run();
        end
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    task automatic stop_run();
        $display("Done: errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(string test, reg_word_t expected, reg_word_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected 0x%08h, actual 0x%08h", test, expected, actual);
            stop_run();
        end
    endtask

    task automatic expect_valid(reg_addr_t addr);
        if (slave_rd_vld_o !== 1'b1) begin
            $display("read of 0x%04h got no valid pulse one cycle after its read enable", addr);
            stop_run();
        end
    endtask

    task automatic bus_write(reg_addr_t addr, reg_word_t data);
        @(posedge clk_i);
        slave_wr_en_i   <= 1'b1;
        slave_addr_i    <= addr;
        slave_wr_data_i <= data;
        @(posedge clk_i);
        slave_wr_en_i   <= 1'b0;
    endtask

    task automatic bus_read(reg_addr_t addr, output reg_word_t data);
        @(posedge clk_i);
        slave_rd_en_i <= 1'b1;
        slave_addr_i  <= addr;
        @(posedge clk_i);
        slave_rd_en_i <= 1'b0;
        @(negedge clk_i);
        expect_valid(addr);
        data = slave_rd_data_o;
    endtask

    // updates the expected copy as well
    task automatic reg_write(int i, reg_word_t data);
        bus_write(REG_ADDR[i], data);
        shadow[i] = data & REG_MASK[i];
    endtask

    function automatic reg_word_t port_value(int i);
        case (i)
            0:       return reg_word_t'(acc_defect_en_o);
            1:       return reg_word_t'(adc_offset_o);
            2:       return reg_word_t'(dac_data_o);
            3:       return reg_word_t'(bst_vcc_en_o);
            4:       return reg_word_t'(pmt_test_en_o);
            5:       return reg_word_t'(pre_acc_curr_thre_o);
            6:       return reg_word_t'(actu_acc_curr_thre_o);
            7:       return reg_word_t'(actu_acc_cache_thre_o);
            8:       return reg_word_t'(particle_acc_bypass_o);
            default: return reg_word_t'(first_track_ctrl_o);
        endcase
    endfunction

    task automatic check_all_regs(string test);
        reg_word_t rd;
        for (int i = 0; i < NUM_REGS; i++) begin
            bus_read(REG_ADDR[i], rd);
            check_value(test, shadow[i], rd);
            check_value({test, " port"}, shadow[i], port_value(i));
        end
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////
    task automatic test_reset_defaults();
        for (int i = 0; i < NUM_REGS; i++) begin
            shadow[i] = REG_DEF[i];
        end
        check_all_regs("reset defaults");
    endtask

    task automatic test_write_readback();
        reg_word_t data;
        reg_word_t rd;
        for (int i = 0; i < NUM_REGS; i++) begin
            data = $random(seed);
            reg_write(i, data);
            @(negedge clk_i);
            check_value("write port", shadow[i], port_value(i));
            bus_read(REG_ADDR[i], rd);
            check_value("write readback", shadow[i], rd);
        end
    endtask

    task automatic test_update_strobes();
        reg_word_t data;
        data = $random(seed);
        reg_write(1, data);
        @(negedge clk_i);
        check_value("adc strobe high", 1, adc_offset_en_o);
        check_value("adc offset value", data & 32'hFFFF, adc_offset_o);
        @(negedge clk_i);
        check_value("adc strobe single", 0, adc_offset_en_o);
        data = $random(seed);
        reg_write(2, data);
        @(negedge clk_i);
        check_value("dac strobe high", 1, dac_config_en_o);
        check_value("dac code value", data & 32'hFFF, dac_data_o);
        @(negedge clk_i);
        check_value("dac strobe single", 0, dac_config_en_o);
        // no pulse for other registers
        reg_write(4, $random(seed));
        repeat (2) begin
            @(negedge clk_i);
            check_value("no adc strobe", 0, adc_offset_en_o);
            check_value("no dac strobe", 0, dac_config_en_o);
        end
    endtask

    task automatic test_info_page();
        reg_word_t rd;
        for (int w = 0; w < 5; w++) begin
            bus_read(16'h1000 + 16'(w * 4), rd);
            check_value("version word", VERSION_WORDS[w], rd);
        end
        // four reads back to back
        @(posedge clk_i);
        slave_rd_en_i <= 1'b1;
        slave_addr_i  <= 16'h1100;
        for (int i = 0; i < 4; i++) begin
            @(posedge clk_i);
            if (i < 3) begin
                slave_addr_i <= 16'h1100 + 16'((i + 1) * 4);
            end else begin
                slave_rd_en_i <= 1'b0;
            end
            @(negedge clk_i);
            expect_valid(16'h1100 + 16'(i * 4));
            check_value("event counter", cnt_vals[i], slave_rd_data_o);
        end
    endtask

    task automatic test_unmapped();
        reg_addr_t bad [6];
        reg_word_t rd;
        bad = '{16'h0028, 16'h0019, 16'h2000, 16'h0218, 16'h1014, 16'h1110};
        foreach (bad[i]) begin
            bus_read(bad[i], rd);
            check_value("unmapped read", 32'h00DEAD00, rd);
        end
        foreach (bad[i]) begin
            bus_write(bad[i], $random(seed));
        end
        // info page indices that page 0 uses for the offset and a threshold
        bus_write(16'h1018, $random(seed));
        bus_write(16'h103C, $random(seed));
        check_all_regs("unmapped write");
    endtask

    initial begin
        seed            = 32'had74;
        cycle_cnt       = 0;
        reset_i         = 1'b1;
        slave_wr_en_i   = 1'b0;
        slave_rd_en_i   = 1'b0;
        slave_addr_i    = '0;
        slave_wr_data_i = '0;
        for (int i = 0; i < 4; i++) begin
            cnt_vals[i] = $random(seed);
        end
        dbg_acc_flag_cnt_i       = cnt_vals[0];
        pre_widen_result_cnt_i   = cnt_vals[1];
        curr_widen_result_cnt_i  = cnt_vals[2];
        cache_widen_result_cnt_i = cnt_vals[3];
        repeat (8) @(posedge clk_i);
        reset_i <= 1'b0;

        test_reset_defaults();
        test_write_readback();
        test_update_strobes();
        test_info_page();
        test_unmapped();

        $display("Done: no errors");
        $finish;
    end

endmodule

// File: src.f
+incdir+.
pmt_regs_pkg.sv
reg_bank_if.sv
pmt_reg_ctrl.sv
pmt_analog_regs.sv
pmt_acc_regs.sv
pmt_info_regs.sv
pmt_reg_map.sv
pmt_reg_map_props.sv
tb_pmt_reg_map.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_pmt_reg_map
FILELIST   := src.f
OBJDIR     := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
